//--- src/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // Word and address widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ADDR_W = 32;

    // RAM geometry, byte address divided by four gives the word index
    localparam int unsigned RAM_WORDS = 1024;
    localparam int unsigned RAM_AW = 10;
    localparam int unsigned WORD_LSB = 2;

    // Address map
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] RAM_LIMIT = 32'h0000_0FFF;
    localparam logic [ADDR_W-1:0] DISPLAY_BASE = 32'h0000_E000;
    localparam logic [ADDR_W-1:0] DISPLAY_LIMIT = 32'h0000_EFFF;
    localparam logic [ADDR_W-1:0] KEYPAD_ADDR = 32'h0000_F000;

    // Load value for unmapped and display reads
    localparam logic [DATA_W-1:0] ERROR_WORD = 32'hDEAD_BEEF;

    // Keypad word layout
    localparam int unsigned KEY_VALID_BIT = 31;
    localparam int unsigned KEY_BTN_LSB = 0;
    localparam int unsigned KEY_BTN_W = 5;
    localparam int unsigned KEY_APP_LSB = 5;
    localparam int unsigned KEY_APP_W = 2;

    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_KEYPAD,
        REGION_DISPLAY,
        REGION_NONE
    } region_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_BUS,
        WB_DONE
    } wb_state_t;

endpackage

`default_nettype wire

//--- src/address_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
    input  logic [mmio_pkg::ADDR_W-1:0] final_address,
    input  logic                        mem_read,
    input  logic                        mem_write,
    output mmio_pkg::region_t           region,
    output logic                        ram_en,
    output logic                        key_en,
    output logic                        display_wen
);
    import mmio_pkg::*;

    logic request;

    // Wraps below base, so one unsigned compare covers both ends
    function automatic logic in_window(input logic [ADDR_W-1:0] addr,
                                       input logic [ADDR_W-1:0] base,
                                       input logic [ADDR_W-1:0] limit);
        return (addr - base) <= (limit - base);
    endfunction

    always_comb begin
        if (in_window(final_address, RAM_BASE, RAM_LIMIT)) begin
            region = REGION_RAM;
        end else if (final_address == KEYPAD_ADDR) begin
            region = REGION_KEYPAD;
        end else if (in_window(final_address, DISPLAY_BASE, DISPLAY_LIMIT)) begin
            region = REGION_DISPLAY;
        end else begin
            region = REGION_NONE;
        end
    end

    assign request = mem_read || mem_write;

    assign ram_en = request && (region == REGION_RAM);
    assign key_en = request && (region == REGION_KEYPAD);
    // Display only takes writes, reads are answered by the merger
    assign display_wen = mem_write && (region == REGION_DISPLAY);

endmodule

`default_nettype wire

//--- src/wishbone_manager.sv
`timescale 1ns/1ps
`default_nettype none

module wishbone_manager (
    input  logic                        clk,
    input  logic                        rst_n,

    // CPU side
    input  logic                        read_req,
    input  logic                        write_req,
    input  logic [mmio_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [mmio_pkg::DATA_W-1:0] cpu_wdata,
    output logic [mmio_pkg::DATA_W-1:0] rdata,
    output logic                        done,

    // Bus side
    output logic [mmio_pkg::RAM_AW-1:0] adr_o,
    output logic [mmio_pkg::DATA_W-1:0] dat_o,
    output logic                        we_o,
    output logic                        stb_o,
    output logic                        cyc_o,
    input  logic [mmio_pkg::DATA_W-1:0] dat_i,
    input  logic                        ack_i
);
    import mmio_pkg::*;

    wb_state_t state;
    wb_state_t state_next;
    logic      start;

    assign start = (state == WB_IDLE) && (read_req || write_req);

    always_comb begin
        state_next = state;
        case (state)
            WB_IDLE: begin
                if (read_req || write_req) begin
                    state_next = WB_BUS;
                end
            end
            WB_BUS: begin
                if (ack_i) begin
                    state_next = WB_DONE;
                end
            end
            // Single cycle of done, then back for the next request
            WB_DONE: state_next = WB_IDLE;
            default: state_next = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WB_IDLE;
            we_o  <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                we_o <= write_req;
            end
        end
    end

    // Address and write data held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_o <= cpu_addr[WORD_LSB +: RAM_AW];
            dat_o <= cpu_wdata;
        end
        if ((state == WB_BUS) && ack_i && !we_o) begin
            rdata <= dat_i;
        end
    end

    assign stb_o = (state == WB_BUS);
    assign cyc_o = (state == WB_BUS);
    assign done  = (state == WB_DONE);

    // Slave may only answer an active strobe
    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> stb_o)
        else $error("wishbone_manager: ack without strobe");

endmodule

`default_nettype wire

//--- src/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [mmio_pkg::RAM_AW-1:0] adr_i,
    input  logic [mmio_pkg::DATA_W-1:0] dat_i,
    input  logic                        we_i,
    input  logic                        stb_i,
    input  logic                        cyc_i,
    output logic [mmio_pkg::DATA_W-1:0] dat_o,
    output logic                        ack_o
);
    import mmio_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic              access;

    // Strobe still high in the ack cycle is the same transfer
    assign access = stb_i && cyc_i && !ack_o;

    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

`default_nettype wire

//--- src/keypad_register.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_register (
    input  logic                           clk,
    input  logic                           rst_n,

    // Keypad scanner
    input  logic                           key_strobe,
    input  logic [mmio_pkg::KEY_BTN_W-1:0] key_button,
    input  logic [mmio_pkg::KEY_APP_W-1:0] key_app,

    // Access from the hub
    input  logic                           key_en,
    input  logic                           mem_read,
    output logic [mmio_pkg::DATA_W-1:0]    key_word,
    output logic                           key_ack
);
    import mmio_pkg::*;

    logic                 pending;
    logic [KEY_BTN_W-1:0] button_q;
    logic [KEY_APP_W-1:0] app_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            key_ack <= 1'b0;
        end else begin
            key_ack <= key_en && !key_ack;
            // A fresh press wins over a read that clears
            if (key_strobe) begin
                pending <= 1'b1;
            end else if (key_ack && mem_read) begin
                pending <= 1'b0;
            end
        end
    end

    // Newest press overwrites the old one
    always_ff @(posedge clk) begin
        if (key_strobe) begin
            button_q <= key_button;
            app_q    <= key_app;
        end
    end

    always_comb begin
        key_word = '0;
        key_word[KEY_VALID_BIT] = pending;
        key_word[KEY_APP_LSB +: KEY_APP_W] = pending ? app_q : '0;
        key_word[KEY_BTN_LSB +: KEY_BTN_W] = pending ? button_q : '0;
    end

endmodule

`default_nettype wire

//--- src/response_merge.sv
`timescale 1ns/1ps
`default_nettype none

module response_merge (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mmio_pkg::region_t           region,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        fetch,
    input  logic [mmio_pkg::DATA_W-1:0] ram_data,
    input  logic                        ram_done,
    input  logic [mmio_pkg::DATA_W-1:0] key_word,
    input  logic                        key_ack,
    input  logic                        display_ack,
    output logic [mmio_pkg::DATA_W-1:0] memload,
    output logic [mmio_pkg::DATA_W-1:0] instruction,
    output logic                        d_ack,
    output logic                        i_ack
);
    import mmio_pkg::*;

    logic local_req;
    logic local_ack;
    logic display_done;
    logic any_ack;
    logic is_fetch;

    always_comb begin
        case (region)
            REGION_RAM:    memload = ram_data;
            REGION_KEYPAD: memload = key_word;
            default:       memload = ERROR_WORD;
        endcase
    end

    assign instruction = memload;

    // Unmapped accesses and display reads are answered here
    assign local_req = ((region == REGION_NONE) && (mem_read || mem_write))
                    || ((region == REGION_DISPLAY) && mem_read && !mem_write);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            local_ack <= 1'b0;
        end else begin
            local_ack <= local_req && !local_ack;
        end
    end

    // Ignore stray display acks
    assign display_done = display_ack && mem_write && (region == REGION_DISPLAY);

    assign any_ack  = ram_done || key_ack || display_done || local_ack;
    assign is_fetch = mem_read && fetch;

    assign i_ack = any_ack && is_fetch;
    assign d_ack = any_ack && !is_fetch;

    // Each access ends with a single pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (d_ack || i_ack) |=> !(d_ack || i_ack))
        else $error("response_merge: acknowledge longer than one cycle");

endmodule

`default_nettype wire

//--- src/mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_top (
    input  logic                           clk,
    input  logic                           rst_n,

    // CPU
    input  logic [mmio_pkg::ADDR_W-1:0]    final_address,
    input  logic [mmio_pkg::DATA_W-1:0]    mem_store,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic                           fetch,
    output logic [mmio_pkg::DATA_W-1:0]    memload,
    output logic [mmio_pkg::DATA_W-1:0]    instruction,
    output logic                           d_ack,
    output logic                           i_ack,

    // Keypad scanner
    input  logic                           key_strobe,
    input  logic [mmio_pkg::KEY_BTN_W-1:0] key_button,
    input  logic [mmio_pkg::KEY_APP_W-1:0] key_app,

    // Display controller
    output logic [mmio_pkg::ADDR_W-1:0]    display_address,
    output logic [mmio_pkg::DATA_W-1:0]    display_data,
    output logic                           display_wen,
    input  logic                           display_ack
);
    import mmio_pkg::*;

    region_t           region;
    logic              ram_en;
    logic              key_en;

    logic [DATA_W-1:0] ram_rdata;
    logic              ram_done;
    logic [DATA_W-1:0] key_word;
    logic              key_ack;

    // Wishbone bus between manager and RAM
    logic [RAM_AW-1:0] wb_adr;
    logic [DATA_W-1:0] wb_wdata;
    logic [DATA_W-1:0] wb_rdata;
    logic              wb_we;
    logic              wb_stb;
    logic              wb_cyc;
    logic              wb_ack;

    assign display_address = final_address;
    assign display_data    = mem_store;

    address_decoder decoder_i (
        .final_address (final_address),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .region        (region),
        .ram_en        (ram_en),
        .key_en        (key_en),
        .display_wen   (display_wen)
    );

    wishbone_manager manager_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .read_req  (ram_en && mem_read),
        .write_req (ram_en && mem_write),
        .cpu_addr  (final_address),
        .cpu_wdata (mem_store),
        .rdata     (ram_rdata),
        .done      (ram_done),
        .adr_o     (wb_adr),
        .dat_o     (wb_wdata),
        .we_o      (wb_we),
        .stb_o     (wb_stb),
        .cyc_o     (wb_cyc),
        .dat_i     (wb_rdata),
        .ack_i     (wb_ack)
    );

    wb_ram ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .adr_i (wb_adr),
        .dat_i (wb_wdata),
        .we_i  (wb_we),
        .stb_i (wb_stb),
        .cyc_i (wb_cyc),
        .dat_o (wb_rdata),
        .ack_o (wb_ack)
    );

    keypad_register keypad_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_strobe (key_strobe),
        .key_button (key_button),
        .key_app    (key_app),
        .key_en     (key_en),
        .mem_read   (mem_read),
        .key_word   (key_word),
        .key_ack    (key_ack)
    );

    response_merge merge_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .region      (region),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .fetch       (fetch),
        .ram_data    (ram_rdata),
        .ram_done    (ram_done),
        .key_word    (key_word),
        .key_ack     (key_ack),
        .display_ack (display_ack),
        .memload     (memload),
        .instruction (instruction),
        .d_ack       (d_ack),
        .i_ack       (i_ack)
    );

endmodule

`default_nettype wire

//--- test/mmio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_tb;
    import mmio_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int STEP_CYCLES  = 20;

    typedef enum {
        OP_READ,
        OP_WRITE,
        OP_FETCH,
        OP_KEYPRESS
    } op_t;

    // One row of the stimulus table
    typedef struct {
        op_t                  op;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    wdata;
        logic [KEY_BTN_W-1:0] button;
        logic [KEY_APP_W-1:0] app;
        logic [DATA_W-1:0]    exp_data;
        byte                  ack_kind;
        int                   latency;
    } step_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [ADDR_W-1:0]    final_address;
    logic [DATA_W-1:0]    mem_store;
    logic                 mem_read;
    logic                 mem_write;
    logic                 fetch;
    logic [DATA_W-1:0]    memload;
    logic [DATA_W-1:0]    instruction;
    logic                 d_ack;
    logic                 i_ack;
    logic                 key_strobe;
    logic [KEY_BTN_W-1:0] key_button;
    logic [KEY_APP_W-1:0] key_app;
    logic [ADDR_W-1:0]    display_address;
    logic [DATA_W-1:0]    display_data;
    logic                 display_wen;
    logic                 display_ack;

    step_t  steps[$];
    logic   table_ready = 1'b0;
    int     error_count = 0;
    int     check_count = 0;
    integer seed = 75311;
    int     display_delay;

    mmio_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .final_address   (final_address),
        .mem_store       (mem_store),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .fetch           (fetch),
        .memload         (memload),
        .instruction     (instruction),
        .d_ack           (d_ack),
        .i_ack           (i_ack),
        .key_strobe      (key_strobe),
        .key_button      (key_button),
        .key_app         (key_app),
        .display_address (display_address),
        .display_data    (display_data),
        .display_wen     (display_wen),
        .display_ack     (display_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Display controller, acks a pending write after 1 to 4 cycles
    always begin
        @(posedge clk);
        if (rst_n && display_wen) begin
            display_delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (display_delay - 1) @(posedge clk);
            display_ack <= 1'b1;
            @(posedge clk);
            display_ack <= 1'b0;
        end
    end

    function automatic logic in_display(input logic [ADDR_W-1:0] addr);
        return (addr >= DISPLAY_BASE) && (addr <= DISPLAY_LIMIT);
    endfunction

    // Pending flag in bit 31, app in 6..5, button in 4..0
    function automatic logic [DATA_W-1:0] key_value(input logic valid,
                                                    input logic [KEY_BTN_W-1:0] button,
                                                    input logic [KEY_APP_W-1:0] app);
        return {valid, 24'h0, app, button};
    endfunction

    task automatic add_step(input op_t op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            input logic [KEY_BTN_W-1:0] button,
                            input logic [KEY_APP_W-1:0] app,
                            input logic [DATA_W-1:0] exp_data,
                            input byte ack_kind, input int latency);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.wdata    = wdata;
        s.button   = button;
        s.app      = app;
        s.exp_data = exp_data;
        s.ack_kind = ack_kind;
        s.latency  = latency;
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("mismatch at %0t: ack latency got %0d expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic apply_step(input int idx);
        step_t s;
        int    waited;
        logic  acked;
        logic  display_write;
        int    errors_before;
        s = steps[idx];
        errors_before = error_count;
        display_write = (s.op == OP_WRITE) && in_display(s.addr);
        if (s.op == OP_KEYPRESS) begin
            @(posedge clk);
            key_strobe <= 1'b1;
            key_button <= s.button;
            key_app    <= s.app;
            @(posedge clk);
            key_strobe <= 1'b0;
        end else begin
            @(posedge clk);
            final_address <= s.addr;
            mem_store     <= s.wdata;
            mem_read      <= (s.op != OP_WRITE);
            mem_write     <= (s.op == OP_WRITE);
            fetch         <= (s.op == OP_FETCH);
            waited = 0;
            acked  = 1'b0;
            while (!acked && (waited < STEP_CYCLES)) begin
                @(negedge clk);
                waited++;
                if (d_ack || i_ack) begin
                    acked = 1'b1;
                end else if (display_write) begin
                    // Write enable has to hold until the display answers
                    check_bit("display_wen", display_wen, 1'b1);
                end
            end
            check_count++;
            assert (acked) else begin
                $display("step %0d: no acknowledge within %0d cycles", idx, STEP_CYCLES);
                error_count++;
            end
            if (acked) begin
                check_bit("d_ack", d_ack, s.ack_kind == "d");
                check_bit("i_ack", i_ack, s.ack_kind == "i");
                if (s.latency >= 0) begin
                    check_latency(waited - 1, s.latency);
                end
                if (s.op == OP_READ) begin
                    check_value("memload", memload, s.exp_data);
                end
                if (s.op == OP_FETCH) begin
                    check_value("instruction", instruction, s.exp_data);
                end
                if (display_write) begin
                    check_value("display_address", display_address, s.addr);
                    check_value("display_data", display_data, s.wdata);
                    check_bit("display_ack", display_ack, 1'b1);
                end else begin
                    check_bit("display_wen", display_wen, 1'b0);
                end
            end
            @(posedge clk);
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            fetch     <= 1'b0;
        end
        $display("step %0d %s addr %h: %s", idx, s.op.name(), s.addr,
                 (error_count == errors_before) ? "ok" : "errors");
    endtask

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((RESET_CYCLES + steps.size() * STEP_CYCLES) * CLK_PERIOD);
        $display("timeout: run did not finish within the allowed %0d cycles",
                 RESET_CYCLES + steps.size() * STEP_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n         <= 1'b0;
        final_address <= '0;
        mem_store     <= '0;
        mem_read      <= 1'b0;
        mem_write     <= 1'b0;
        fetch         <= 1'b0;
        key_strobe    <= 1'b0;
        key_button    <= '0;
        key_app       <= '0;
        display_ack   <= 1'b0;

        // RAM writes and read-back, latency of three cycles
        add_step(OP_WRITE, 32'h0000_0000, 32'h1111_0000, 5'h00, 2'd0, 32'h0, "d", 3);
        add_step(OP_WRITE, 32'h0000_0004, 32'hCAFE_0004, 5'h00, 2'd0, 32'h0, "d", 3);
        add_step(OP_WRITE, 32'h0000_0FFC, 32'h5A5A_A5A5, 5'h00, 2'd0, 32'h0, "d", 3);
        add_step(OP_WRITE, 32'h0000_0100, 32'h0BAD_F00D, 5'h00, 2'd0, 32'h0, "d", 3);
        add_step(OP_READ, 32'h0000_0000, 32'h0, 5'h00, 2'd0, 32'h1111_0000, "d", 3);
        add_step(OP_READ, 32'h0000_0004, 32'h0, 5'h00, 2'd0, 32'hCAFE_0004, "d", 3);
        add_step(OP_READ, 32'h0000_0FFC, 32'h0, 5'h00, 2'd0, 32'h5A5A_A5A5, "d", 3);
        add_step(OP_FETCH, 32'h0000_0100, 32'h0, 5'h00, 2'd0, 32'h0BAD_F00D, "i", 3);

        // Keypad press, then a read that clears and one that finds nothing
        add_step(OP_KEYPRESS, 32'h0, 32'h0, 5'h13, 2'd2, 32'h0, "-", -1);
        add_step(OP_READ, KEYPAD_ADDR, 32'h0, 5'h00, 2'd0,
                 key_value(1'b1, 5'h13, 2'd2), "d", 1);
        add_step(OP_READ, KEYPAD_ADDR, 32'h0, 5'h00, 2'd0,
                 key_value(1'b0, 5'h00, 2'd0), "d", 1);

        // Newer press overwrites the older one
        add_step(OP_KEYPRESS, 32'h0, 32'h0, 5'h03, 2'd1, 32'h0, "-", -1);
        add_step(OP_KEYPRESS, 32'h0, 32'h0, 5'h1F, 2'd3, 32'h0, "-", -1);
        add_step(OP_READ, KEYPAD_ADDR, 32'h0, 5'h00, 2'd0,
                 key_value(1'b1, 5'h1F, 2'd3), "d", 1);

        // Display write aliases RAM word 0, which must stay intact
        add_step(OP_WRITE, 32'h0000_E000, 32'h1234_5678, 5'h00, 2'd0, 32'h0, "d", -1);
        add_step(OP_READ, 32'h0000_0000, 32'h0, 5'h00, 2'd0, 32'h1111_0000, "d", 3);

        // Unmapped and display reads
        add_step(OP_READ, 32'h0000_8000, 32'h0, 5'h00, 2'd0, ERROR_WORD, "d", 1);
        add_step(OP_READ, 32'h0000_E010, 32'h0, 5'h00, 2'd0, ERROR_WORD, "d", 1);
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
        end

        $display("summary: %0d steps, %0d checks, %0d errors",
                 steps.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/mmio_pkg.sv
src/address_decoder.sv
src/wishbone_manager.sv
src/wb_ram.sv
src/keypad_register.sv
src/response_merge.sv
src/mmio_top.sv
test/mmio_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MMIO hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mmio_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmmio_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
else
    echo "run.sh: pass message not found in simulation output"
    exit 1
fi
